// ==== verilog.f ====
+incdir+dv
source/resadd_pkg.sv
source/skip_fifo.sv
source/fp32_adder.sv
source/elem_counter.sv
source/layer_sequencer.sv
source/residual_add.sv
dv/tb_residual_add.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the residual-add testbench with Verilator, run it, grep the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_residual_add -f verilog.f \
  -o sim_residual_add > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_residual_add > sim.log 2>&1
cat sim.log
grep -qx "Finished with no errors" sim.log \
  && { echo "Simulation result: pass"; exit 0; } \
  || { echo "Simulation result: fail, see sim.log"; exit 1; }

// ==== dv/fp_add_model.svh ====
`ifndef FP_ADD_MODEL_SVH
`define FP_ADD_MODEL_SVH

// Reference for one fp32 sum
// Nearest-even rounding, subnormals flushed, overflow to infinity
// Exact sum on a wide fixed-point grid, then a single rounding
function automatic fp32_t fp_add_model(input fp32_t a, input fp32_t b);
  fp32_t       x;
  fp32_t       y;
  fp32_t       t;
  logic [79:0] bx;
  logic [79:0] sy;
  logic [79:0] s;
  logic [23:0] m;
  logic [24:0] mr;
  logic        half;
  logic        sticky;
  int          diff;
  int          p;
  int          e;
  x = a;
  y = b;
  // Subnormal operands count as signed zero
  if (x.exponent == 8'd0) x.mantissa = 23'd0;
  if (y.exponent == 8'd0) y.mantissa = 23'd0;
  // x keeps the larger magnitude
  if ({y.exponent, y.mantissa} > {x.exponent, x.mantissa}) begin
    t = x;
    x = y;
    y = t;
  end
  if (x.exponent == 8'd0) return fp32_t'{x.sign & y.sign, 8'd0, 23'd0};
  if (y.exponent == 8'd0) return x;
  diff = int'(x.exponent) - int'(y.exponent);
  // Hidden bit of x at bit 71
  bx = {56'd0, 1'b1, x.mantissa} << 48;
  // Far below the grid, one unit keeps the rounding side
  if (diff >= 48) sy = 80'd1;
  else sy = {56'd0, 1'b1, y.mantissa} << (48 - diff);
  s = (x.sign != y.sign) ? (bx - sy) : (bx + sy);
  // Exact cancellation
  if (s == 80'd0) return '0;
  p = 79;
  while (!s[p]) p--;
  m      = 24'(s >> (p - 23));
  half   = s[p - 24];
  sticky = (s & ((80'd1 << (p - 24)) - 80'd1)) != 80'd0;
  mr = {1'b0, m} + {24'd0, half && (sticky || m[0])};
  e  = int'(x.exponent) + p - 71;
  // Carry out of rounding bumps the exponent
  if (mr[24]) begin
    mr = mr >> 1;
    e  = e + 1;
  end
  if (e <= 0) return fp32_t'{x.sign, 8'd0, 23'd0};
  if (e >= 255) return fp32_t'{x.sign, 8'hFF, 23'd0};
  return fp32_t'{x.sign, 8'(e), mr[22:0]};
endfunction

`endif

// ==== dv/tb_residual_add.sv ====
`timescale 1ns/1ps

module tb_residual_add import resadd_pkg::*; ();

  `include "fp_add_model.svh"

  logic                  clk;
  logic                  reset;
  logic                  start;
  logic [ELEM_CNT_W-1:0] num_elems;
  logic                  main_valid;
  fp32_t                 main_data;
  logic                  skip_valid;
  fp32_t                 skip_data;
  logic                  sum_valid;
  fp32_t                 sum_data;
  layer_status_t         status;

  // Model state
  logic [31:0] rand_state = 32'h28f82c81;
  fp32_t       skip_q[$];
  fp32_t       exp_sum_q[$];
  int          exp_cyc_q[$];
  fp32_t       main_vals[$];
  fp32_t       skip_vals[$];
  logic        model_run = 1'b0;
  logic        exp_overflow = 1'b0;
  logic        exp_underflow = 1'b0;
  int          last_sum_cyc = 0;
  int          done_count = 0;

  // Run bookkeeping
  int cyc = 0;
  int cycle_limit = 0;
  int errors = 0;
  int test_errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;

  residual_add u_residual_add (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .num_elems  (num_elems),
    .main_valid (main_valid),
    .main_data  (main_data),
    .skip_valid (skip_valid),
    .skip_data  (skip_data),
    .sum_valid  (sum_valid),
    .sum_data   (sum_data),
    .status     (status)
  );

  //////////////////////////////
  // Clock and cycle limit
  //////////////////////////////

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > cycle_limit) begin
      $display("Timeout: run still going after %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // LCG, 32-bit state
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Bounded exponent, no NaN or infinity
  function automatic fp32_t rand_float();
    logic [31:0] r;
    fp32_t       f;
    r = next_rand();
    f.sign     = r[31];
    f.exponent = 8'd110 + (r[23:16] % 8'd36);
    r = next_rand();
    f.mantissa = r[31:9];
    return f;
  endfunction

  task automatic compare(input string what, input logic [31:0] got,
                         input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      $display("ERR %0t: %s got %h expected %h", $time, what, got, expected);
      errors++;
      test_errors++;
    end
  endtask

  // FIFO rule: read sees the occupancy before this cycle's write
  task automatic model_step(input logic mv, input fp32_t md, input logic sv, input fp32_t sd);
    int   depth;
    logic rd_ok;
    logic wr_ok;
    depth = skip_q.size();
    rd_ok = mv && (depth > 0);
    wr_ok = sv && ((depth < SKIP_FIFO_DEPTH) || rd_ok);
    if (mv && !rd_ok) exp_underflow = 1'b1;
    if (sv && !wr_ok) exp_overflow = 1'b1;
    if (rd_ok) begin
      exp_sum_q.push_back(fp_add_model(md, skip_q.pop_front()));
      // Accept edge, then FIFO read and adder stages
      exp_cyc_q.push_back(cyc + 1 + FP_ADD_LATENCY);
    end
    if (wr_ok) skip_q.push_back(sd);
  endtask

  // One cycle of branch inputs, set on the falling edge
  task automatic drive(input logic mv, input fp32_t md, input logic sv, input fp32_t sd);
    @(negedge clk);
    start      = 1'b0;
    main_valid = mv;
    main_data  = md;
    skip_valid = sv;
    skip_data  = sd;
    if (model_run) model_step(mv, md, sv, sd);
  endtask

  task automatic start_layer(input int n);
    @(negedge clk);
    start         = 1'b1;
    num_elems     = ELEM_CNT_W'(n);
    main_valid    = 1'b0;
    skip_valid    = 1'b0;
    exp_overflow  = 1'b0;
    exp_underflow = 1'b0;
    model_run     = 1'b1;
    @(negedge clk);
    start     = 1'b0;
    num_elems = '0;
  endtask

  task automatic wait_done(input int limit);
    int waited;
    waited = 0;
    while (!status.done && waited < limit) begin
      drive(1'b0, '0, 1'b0, '0);
      waited++;
    end
    if (!status.done) begin
      $display("Layer done never came within %0d cycles", limit);
      errors++;
      test_errors++;
    end
    model_run = 1'b0;
  endtask

  task automatic fill_random(input int n);
    main_vals.delete();
    skip_vals.delete();
    repeat (n) begin
      main_vals.push_back(rand_float());
      skip_vals.push_back(rand_float());
    end
  endtask

  task automatic add_pair(input logic [31:0] a, input logic [31:0] b);
    main_vals.push_back(fp32_t'(a));
    skip_vals.push_back(fp32_t'(b));
  endtask

  // Skip leads by one cycle, then both branches together
  task automatic run_pairs(input logic check_busy);
    int n;
    n = main_vals.size();
    drive(1'b0, '0, 1'b1, skip_vals[0]);
    for (int i = 1; i < n; i++) begin
      drive(1'b1, main_vals[i-1], 1'b1, skip_vals[i]);
      if (check_busy) compare("busy during run", 32'(status.busy), 32'd1);
    end
    drive(1'b1, main_vals[n-1], 1'b0, '0);
  endtask

  // Skip bursts refill only once the buffer has drained
  task automatic run_skip_lead(input int n);
    int          skips_sent;
    int          mains_sent;
    int          burst_left;
    logic [31:0] r;
    logic        sv;
    logic        mv;
    skips_sent = 0;
    mains_sent = 0;
    burst_left = 0;
    while (mains_sent < n) begin
      r = next_rand();
      if (burst_left == 0 && skip_q.size() == 0) begin
        burst_left = 1 + int'(r[19:16]);
        if (burst_left > n - skips_sent) burst_left = n - skips_sent;
      end
      sv = (burst_left > 0) && r[24];
      mv = (skip_q.size() > 0) && r[28];
      drive(mv, rand_float(), sv, rand_float());
      if (sv) begin
        burst_left--;
        skips_sent++;
      end
      if (mv) mains_sent++;
    end
  endtask

  task automatic end_test(input string name);
    compare("sums left pending", exp_sum_q.size(), 0);
    compare("skip overflow flag", 32'(status.skip_overflow), 32'(exp_overflow));
    compare("skip underflow flag", 32'(status.skip_underflow), 32'(exp_underflow));
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
      $display("%s: FAILED, %0d errors", name, test_errors);
    end else begin
      $display("%s: passed", name);
    end
    test_errors = 0;
  endtask

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  always @(negedge clk) begin
    if (!reset) begin
      if (sum_valid) begin
        if (exp_sum_q.size() == 0) begin
          $display("Unexpected sum %h at %0t with nothing pending", sum_data, $time);
          errors++;
          test_errors++;
        end else begin
          compare("sum data", sum_data, exp_sum_q.pop_front());
          compare("sum cycle", cyc, exp_cyc_q.pop_front());
        end
        last_sum_cyc = cyc;
      end
      // Done follows the final sum by one cycle
      if (status.done) begin
        done_count++;
        compare("done cycle", cyc, last_sum_cyc + 1);
      end
    end
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    int          len_aligned;
    int          len_lead;
    int          len_frame_max;
    int          len_corner;
    int          len_error;
    int          frame_n;
    int          done_before;
    logic [31:0] r;
    len_aligned   = 64;
    len_lead      = 48;
    len_frame_max = 32;
    len_corner    = 12;
    len_error     = 2 * SKIP_FIFO_DEPTH + 8;
    // Generous cycles per element, plus reset and drain
    cycle_limit = 8 * (len_aligned + len_lead + len_frame_max + len_corner + len_error) + 200;
    reset      = 1'b1;
    start      = 1'b0;
    num_elems  = '0;
    main_valid = 1'b0;
    main_data  = '0;
    skip_valid = 1'b0;
    skip_data  = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Both branches in step
    fill_random(len_aligned);
    start_layer(len_aligned);
    run_pairs(1'b0);
    wait_done(20);
    end_test("aligned streams");

    // Skip branch ahead in bursts
    start_layer(len_lead);
    run_skip_lead(len_lead);
    wait_done(20);
    end_test("skip leading");

    // Inputs while IDLE must vanish
    repeat (5) drive(1'b1, rand_float(), 1'b1, rand_float());
    r = next_rand();
    frame_n = 1 + int'(r[20:16]);
    fill_random(frame_n);
    done_before = done_count;
    start_layer(frame_n);
    compare("busy after start", 32'(status.busy), 32'd1);
    run_pairs(1'b1);
    wait_done(20);
    repeat (8) drive(1'b1, rand_float(), 1'b1, rand_float());
    compare("done pulses", done_count - done_before, 1);
    compare("busy after done", 32'(status.busy), 32'd0);
    end_test("framing");

    // Cancellation, wide shifts, round carries, overflow, flush
    main_vals.delete();
    skip_vals.delete();
    add_pair(32'h3fc00000, 32'hbfc00000);
    add_pair(32'hc0300000, 32'h40300000);
    add_pair(32'h3f800000, 32'h30800000);
    add_pair(32'h3f800000, 32'hb2800000);
    add_pair(32'h4b000001, 32'h3f000000);
    add_pair(32'h3fffffff, 32'h33800000);
    add_pair(32'h3f7fffff, 32'h33000000);
    add_pair(32'h7f7fffff, 32'h7f7fffff);
    add_pair(32'hff7fffff, 32'hff000000);
    add_pair(32'h00800001, 32'h80800000);
    add_pair(32'h80900000, 32'h00800000);
    add_pair(32'h00000005, 32'h3f800000);
    start_layer(main_vals.size());
    run_pairs(1'b0);
    wait_done(20);
    end_test("arithmetic corners");

    // Overflow on a full FIFO, then underflow on an empty one
    start_layer(SKIP_FIFO_DEPTH + 1);
    repeat (SKIP_FIFO_DEPTH + 1) drive(1'b0, '0, 1'b1, rand_float());
    repeat (SKIP_FIFO_DEPTH + 1) drive(1'b1, rand_float(), 1'b0, '0);
    drive(1'b0, '0, 1'b1, rand_float());
    drive(1'b1, rand_float(), 1'b0, '0);
    wait_done(20);
    compare("overflow flag set", 32'(status.skip_overflow), 32'd1);
    compare("underflow flag set", 32'(status.skip_underflow), 32'd1);
    // New start wipes both
    start_layer(1);
    compare("overflow flag cleared", 32'(status.skip_overflow), 32'd0);
    compare("underflow flag cleared", 32'(status.skip_underflow), 32'd0);
    drive(1'b0, '0, 1'b1, rand_float());
    drive(1'b1, rand_float(), 1'b0, '0);
    wait_done(20);
    end_test("error flags");

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== source/residual_add.sv ====
`timescale 1ns/1ps

module residual_add import resadd_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic [ELEM_CNT_W-1:0] num_elems,
  input  logic                  main_valid,
  input  fp32_t                 main_data,
  input  logic                  skip_valid,
  input  fp32_t                 skip_data,
  output logic                  sum_valid,
  output fp32_t                 sum_data,
  output layer_status_t         status
);

  logic  run_en;
  logic  load;
  logic  last;
  logic  main_v;
  logic  skip_v;
  fp32_t main_d;
  logic  main_d_valid;
  fp32_t fifo_rd_data;
  logic  fifo_rd_valid;
  logic  fifo_overflow;
  logic  fifo_underflow;
  logic  add_valid;

  //////////////////////////////
  // Branch gating
  //////////////////////////////

  // Inputs ignored outside RUN
  assign main_v = main_valid && run_en;
  assign skip_v = skip_valid && run_en;

  // Skip values wait here, each main value pulls one
  skip_fifo u_skip_fifo (
    .clk       (clk),
    .reset     (reset),
    .wr_en     (skip_v),
    .wr_data   (skip_data),
    .rd_en     (main_v),
    .rd_data   (fifo_rd_data),
    .rd_valid  (fifo_rd_valid),
    .overflow  (fifo_overflow),
    .underflow (fifo_underflow)
  );

  //////////////////////////////
  // Main branch delay
  //////////////////////////////

  // Matches the registered FIFO read
  always_ff @(posedge clk) begin
    main_d <= main_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      main_d_valid <= 1'b0;
    end else begin
      main_d_valid <= main_v;
    end
  end

  // No sum when the FIFO read came back empty
  assign add_valid = main_d_valid && fifo_rd_valid;

  fp32_adder u_fp32_adder (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (add_valid),
    .in_a      (main_d),
    .in_b      (fifo_rd_data),
    .valid_out (sum_valid),
    .sum       (sum_data)
  );

  //////////////////////////////
  // Layer framing
  //////////////////////////////

  elem_counter u_elem_counter (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .target   (num_elems),
    .count_en (sum_valid),
    .last     (last)
  );

  layer_sequencer u_layer_sequencer (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .last           (last),
    .fifo_overflow  (fifo_overflow),
    .fifo_underflow (fifo_underflow),
    .run_en         (run_en),
    .load           (load),
    .status         (status)
  );

endmodule

// ==== source/layer_sequencer.sv ====
`timescale 1ns/1ps

module layer_sequencer import resadd_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          start,
  input  logic          last,
  input  logic          fifo_overflow,
  input  logic          fifo_underflow,
  output logic          run_en,
  output logic          load,
  output layer_status_t status
);

  seq_state_t state;
  seq_state_t state_next;

  logic overflow_q;
  logic underflow_q;

  // Start honored only from IDLE
  assign load = start && (state == IDLE);

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      IDLE:    if (start) state_next = RUN;
      RUN:     if (last) state_next = DONE;
      // One cycle for the done pulse
      DONE:    state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  //////////////////////////////
  // Sticky error flags
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || load) begin
      overflow_q  <= 1'b0;
      underflow_q <= 1'b0;
    end else begin
      if (fifo_overflow)  overflow_q  <= 1'b1;
      if (fifo_underflow) underflow_q <= 1'b1;
    end
  end

  // Branches open only while running
  assign run_en = (state == RUN);

  assign status.busy           = (state == RUN);
  assign status.done           = (state == DONE);
  assign status.skip_overflow  = overflow_q;
  assign status.skip_underflow = underflow_q;

endmodule

// ==== source/elem_counter.sv ====
`timescale 1ns/1ps

module elem_counter import resadd_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  load,
  input  logic [ELEM_CNT_W-1:0] target,
  input  logic                  count_en,
  output logic                  last
);

  logic [ELEM_CNT_W-1:0] target_q;
  logic [ELEM_CNT_W-1:0] count_q;

  //////////////////////////////
  // Count of emitted sums
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      target_q <= '0;
      count_q  <= '0;
    end else if (load) begin
      // New layer, fresh target
      target_q <= target;
      count_q  <= '0;
    end else if (count_en) begin
      count_q <= count_q + 1'b1;
    end
  end

  // High on the strobe that completes the target
  assign last = count_en && (count_q == (target_q - ELEM_CNT_W'(1)));

endmodule

// ==== source/fp32_adder.sv ====
`timescale 1ns/1ps

module fp32_adder import resadd_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  valid_in,
  input  fp32_t in_a,
  input  fp32_t in_b,
  output logic  valid_out,
  output fp32_t sum
);

  // Valid chain with one bit per stage
  logic [FP_ADD_LATENCY-1:0] valid_pipe;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[FP_ADD_LATENCY-2:0], valid_in};
    end
  end

  assign valid_out = valid_pipe[FP_ADD_LATENCY-1];

  //////////////////////////////
  // Stage 1 flushes, orders and aligns
  //////////////////////////////

  logic        a_zero;
  logic        b_zero;
  logic [30:0] mag_a;
  logic [30:0] mag_b;
  logic        swap;
  fp32_t       big;
  fp32_t       small_op;
  logic [23:0] big_man;
  logic [23:0] small_man;
  logic [7:0]  exp_diff;
  logic [4:0]  shamt;
  logic [49:0] small_wide;

  // Subnormals count as zero
  assign a_zero = (in_a.exponent == 8'd0);
  assign b_zero = (in_b.exponent == 8'd0);
  assign mag_a  = a_zero ? 31'd0 : {in_a.exponent, in_a.mantissa};
  assign mag_b  = b_zero ? 31'd0 : {in_b.exponent, in_b.mantissa};

  // Larger magnitude goes first
  assign swap     = (mag_b > mag_a);
  assign big      = swap ? fp32_t'{in_b.sign, mag_b[30:23], mag_b[22:0]}
                         : fp32_t'{in_a.sign, mag_a[30:23], mag_a[22:0]};
  assign small_op = swap ? fp32_t'{in_a.sign, mag_a[30:23], mag_a[22:0]}
                         : fp32_t'{in_b.sign, mag_b[30:23], mag_b[22:0]};

  // Hidden one only for normal values
  assign big_man   = {(big.exponent != 8'd0), big.mantissa};
  assign small_man = {(small_op.exponent != 8'd0), small_op.mantissa};

  // Beyond 26 everything lands in sticky anyway
  assign exp_diff = big.exponent - small_op.exponent;
  assign shamt    = (exp_diff > 8'd26) ? 5'd26 : exp_diff[4:0];

  // Top 24 bits line up with big_man and the rest feeds guard, round and sticky
  assign small_wide = {small_man, 26'd0} >> shamt;

  logic        s1_sign;
  logic        s1_sub;
  logic [7:0]  s1_exp;
  logic [23:0] s1_big;
  logic [26:0] s1_small;

  always_ff @(posedge clk) begin
    s1_sign  <= big.sign;
    s1_sub   <= in_a.sign ^ in_b.sign;
    s1_exp   <= big.exponent;
    s1_big   <= big_man;
    s1_small <= {small_wide[49:24], |small_wide[23:0]};
  end

  //////////////////////////////
  // Stage 2 adds or subtracts mantissas
  //////////////////////////////

  logic [27:0] big_ext;
  logic [27:0] small_ext;

  // Bit 27 catches the carry
  assign big_ext   = {1'b0, s1_big, 3'b000};
  assign small_ext = {1'b0, s1_small};

  logic        s2_sign;
  logic        s2_sub;
  logic [7:0]  s2_exp;
  logic [27:0] s2_sum;

  // Big is never below small, so the difference stays positive
  always_ff @(posedge clk) begin
    s2_sign <= s1_sign;
    s2_sub  <= s1_sub;
    s2_exp  <= s1_exp;
    s2_sum  <= s1_sub ? (big_ext - small_ext) : (big_ext + small_ext);
  end

  //////////////////////////////
  // Stage 3 normalizes and rounds
  //////////////////////////////

  function automatic logic [4:0] count_lz(input logic [27:0] value);
    logic [4:0] n;
    logic       found;
    n = 5'd0;
    found = 1'b0;
    for (int i = 27; i >= 0; i--) begin
      if (!found && value[i]) found = 1'b1;
      else if (!found) n = n + 5'd1;
    end
    return n;
  endfunction

  logic [4:0]  lz;
  logic [27:0] norm;
  logic        guard_bit;
  logic        sticky_bit;
  logic        round_up;
  logic [24:0] man_rnd;
  logic [9:0]  exp_res;
  fp32_t       result;

  assign lz   = count_lz(s2_sum);
  assign norm = s2_sum << lz;

  // Nearest even rounds up above half or at half with odd lsb
  assign guard_bit  = norm[3];
  assign sticky_bit = |norm[2:0];
  assign round_up   = guard_bit && (sticky_bit || norm[4]);
  assign man_rnd    = {1'b0, norm[27:4]} + {24'd0, round_up};

  // Bit 26 is the hidden position at the big exponent
  // Negative results wrap and show in bit 9
  assign exp_res = {2'b00, s2_exp} + 10'd1 + {9'd0, man_rnd[24]} - {5'd0, lz};

  always_comb begin
    if (s2_sum == 28'd0) begin
      // Cancellation gives +0 and like-signed zeros keep their sign
      result = fp32_t'{s2_sign && !s2_sub, 8'd0, 23'd0};
    end else if (exp_res[9] || exp_res == 10'd0) begin
      // Below normal range flushes to signed zero
      result = fp32_t'{s2_sign, 8'd0, 23'd0};
    end else if (exp_res >= 10'd255) begin
      result = fp32_t'{s2_sign, 8'hFF, 23'd0};
    end else begin
      // Rounding carry leaves an all-zero fraction
      result.sign     = s2_sign;
      result.exponent = exp_res[7:0];
      result.mantissa = man_rnd[22:0];
    end
  end

  always_ff @(posedge clk) begin
    sum <= result;
  end

endmodule

// ==== source/skip_fifo.sv ====
`timescale 1ns/1ps

module skip_fifo import resadd_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  wr_en,
  input  fp32_t wr_data,
  input  logic  rd_en,
  output fp32_t rd_data,
  output logic  rd_valid,
  output logic  overflow,
  output logic  underflow
);

  //////////////////////////////
  // Storage and pointers
  //////////////////////////////

  fp32_t mem [SKIP_FIFO_DEPTH];

  logic [SKIP_PTR_W-1:0] wr_ptr;
  logic [SKIP_PTR_W-1:0] rd_ptr;
  // One extra bit so a full buffer is distinct from empty
  logic [SKIP_PTR_W:0]   count;

  logic full;
  logic empty;
  logic wr_ok;
  logic rd_ok;

  assign full  = (count == (SKIP_PTR_W+1)'(SKIP_FIFO_DEPTH));
  assign empty = (count == '0);

  // Read only from a non-empty buffer
  assign rd_ok = rd_en && !empty;
  // Write at full only when a read frees a slot this cycle
  assign wr_ok = wr_en && (!full || rd_ok);

  // Error pulses, same cycle as the offending strobe
  assign overflow  = wr_en && !wr_ok;
  assign underflow = rd_en && empty;

  //////////////////////////////
  // Pointer and occupancy
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Depth is a power of two, pointers wrap naturally
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Buffer write
  always_ff @(posedge clk) begin
    if (wr_ok) mem[wr_ptr] <= wr_data;
  end

  //////////////////////////////
  // Registered read
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rd_ok) rd_data <= mem[rd_ptr];
  end

  // Flag travels with the data
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_ok;
    end
  end

endmodule

// ==== source/resadd_pkg.sv ====
package resadd_pkg;

  //////////////////////////////
  // Float format
  //////////////////////////////

  // IEEE single precision, msb first
  typedef struct packed {
    logic       sign;
    logic [7:0] exponent;
    logic [22:0] mantissa;
  } fp32_t;

  //////////////////////////////
  // Layer status
  //////////////////////////////

  // Busy and done follow the sequencer state
  // Error bits are sticky until the next start
  typedef struct packed {
    logic busy;
    logic done;
    logic skip_overflow;
    logic skip_underflow;
  } layer_status_t;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } seq_state_t;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Skip branch buffer entries
  localparam int SKIP_FIFO_DEPTH = 16;
  // Pointer width, log2 of the depth
  localparam int SKIP_PTR_W = 4;

  // Element count width
  localparam int ELEM_CNT_W = 16;

  // Adder stages from valid_in to valid_out
  localparam int FP_ADD_LATENCY = 3;

endpackage
